/* Makefile */
VERILATOR  ?= verilator
FLAGS      = --binary --timing --assert -j 0
LINT_FLAGS = --lint-only --timing
TOP        = cpuTb
FILELIST   = verilog.f
BUILD_DIR  = obj_dir
LOG        = sim.log

.PHONY: lint sim clean

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -qx "all tests passed" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* dv/cpuSva.sv */
`timescale 1ns/100ps
`default_nettype none

module cpuSva (
  input logic        clk,
  input logic        reset,
  input logic        readReq,
  input logic        writeReq,
  input logic        readAck,
  input logic        writeAck,
  input logic [31:0] ramAddress
);

  logic outstanding;
  int   assertFails = 0;

  // Request still waiting for its acknowledge
  // Ack wins since a one-cycle ack is sampled with its request
  always_ff @(posedge clk or posedge reset)
  begin
    if (reset)
      outstanding <= 1'b0;
    else if (readAck || writeAck)
      outstanding <= 1'b0;
    else if (readReq || writeReq)
      outstanding <= 1'b1;
  end

  noOverlap: assert property (@(posedge clk) disable iff (reset) !(readReq && writeReq))
    else
    begin
      $error("readReq and writeReq high in the same cycle");
      assertFails++;
    end

  singleReadCycle: assert property (@(posedge clk) disable iff (reset) readReq |=> !readReq)
    else
    begin
      $error("readReq held longer than one cycle");
      assertFails++;
    end

  singleWriteCycle: assert property (@(posedge clk) disable iff (reset) writeReq |=> !writeReq)
    else
    begin
      $error("writeReq held longer than one cycle");
      assertFails++;
    end

  // One transaction in flight
  noEarlyRequest: assert property (@(posedge clk) disable iff (reset)
    outstanding |-> !(readReq || writeReq))
    else
    begin
      $error("new request before the previous acknowledge");
      assertFails++;
    end

  stableAddress: assert property (@(posedge clk) disable iff (reset)
    (readReq || writeReq || outstanding) && !(readAck || writeAck) |=> $stable(ramAddress))
    else
    begin
      $error("ramAddress changed while a request was outstanding");
      assertFails++;
    end

endmodule

bind cpuTop cpuSva i_cpuSva (
  .clk       (clk),
  .reset     (reset),
  .readReq   (readReq),
  .writeReq  (writeReq),
  .readAck   (readAck),
  .writeAck  (writeAck),
  .ramAddress(ramAddress)
);

`default_nettype wire

/* dv/cpuTb.sv */
`timescale 1ns/100ps
`default_nettype none

module cpuTb;

  // Compare bits of register 1
  localparam logic [31:0] lessBit    = 32'h2;
  localparam logic [31:0] greaterBit = 32'h4;
  localparam int timeoutCycles = 1000;

  logic        clk;
  logic        reset;
  logic [31:0] ramIn;
  logic        readAck;
  logic        writeAck;
  logic [31:0] ramAddress;
  logic [31:0] ramOut;
  logic        readReq;
  logic        writeReq;

  logic [31:0] mem [0:1023];
  logic [31:0] readLog[$];
  logic [31:0] writeAddrLog[$];
  logic [31:0] writeDataLog[$];
  logic [31:0] expectedReads[$];
  logic [31:0] firstArithData[$];
  logic [31:0] arithConst [4];
  logic [31:0] pendAddr;
  logic [31:0] pendData;
  int          seed = 24;
  int          errorCount = 0;
  int          checkCount = 0;
  int          codePtr;
  int          waitLeft;
  bit          randomAck;
  bit          pendActive;
  bit          pendWrite;

  tbClockGen i_tbClockGen (
    .clk(clk)
  );

  cpuTop #(
    .regCount(16)
  ) i_cpuTop (
    .clk       (clk),
    .reset     (reset),
    .ramIn     (ramIn),
    .readAck   (readAck),
    .writeAck  (writeAck),
    .ramAddress(ramAddress),
    .ramOut    (ramOut),
    .readReq   (readReq),
    .writeReq  (writeReq)
  );

  // RAM model acting on the falling edge
  always @(negedge clk)
  begin
    readAck  = 1'b0;
    writeAck = 1'b0;
    if (reset)
      pendActive = 1'b0;
    else
    begin
      if (readReq || writeReq)
      begin
        pendActive = 1'b1;
        pendWrite  = writeReq;
        pendAddr   = ramAddress;
        pendData   = ramOut;
        waitLeft   = randomAck ? 1 + ($unsigned($random(seed)) % 5) : 1;
      end
      if (pendActive)
      begin
        // Delay of 1 answers in the request cycle itself
        if (waitLeft > 1)
          waitLeft--;
        else
        begin
          pendActive = 1'b0;
          if (pendWrite)
          begin
            mem[pendAddr[11:2]] = pendData;
            writeAddrLog.push_back(pendAddr);
            writeDataLog.push_back(pendData);
            writeAck = 1'b1;
          end
          else
          begin
            ramIn = mem[pendAddr[11:2]];
            readLog.push_back(pendAddr);
            readAck = 1'b1;
          end
        end
      end
    end
  end

  // Opcode in byte 0, register fields in bytes 1 and 2
  function automatic logic [31:0] encode(input logic [7:0] op, input logic [7:0] ra,
                                         input logic [7:0] rb);
    return {8'h00, rb, ra, op};
  endfunction

  task automatic emitShort(input logic [7:0] op, input logic [7:0] ra, input logic [7:0] rb);
    mem[codePtr >> 2] = encode(op, ra, rb);
    codePtr += 4;
  endtask

  task automatic emitLong(input logic [7:0] op, input logic [7:0] ra, input logic [7:0] rb,
                          input logic [31:0] constant);
    emitShort(op, ra, rb);
    mem[codePtr >> 2] = constant;
    codePtr += 4;
  endtask

  // Core held in reset while RAM and logs are cleared
  task automatic holdReset();
    @(negedge clk);
    reset     = 1'b1;
    randomAck = 1'b0;
    codePtr   = 0;
    for (int i = 0; i < 1024; i++)
      mem[i] = '0;
    readLog.delete();
    writeAddrLog.delete();
    writeDataLog.delete();
  endtask

  task automatic releaseReset();
    repeat (3) @(negedge clk);
    reset = 1'b0;
  endtask

  task automatic checkValue(input string name, input logic [31:0] got,
                            input logic [31:0] expected);
    checkCount++;
    assert (got === expected)
    else
    begin
      $display("[ERROR] time %0t: %s is %h, expected %h", $time, name, got, expected);
      errorCount++;
    end
  endtask

  task automatic checkWrite(input int index, input logic [31:0] address,
                            input logic [31:0] data);
    assert (index < writeAddrLog.size())
    else
    begin
      $display("RAM write number %0d never happened", index);
      errorCount++;
    end
    if (index < writeAddrLog.size())
    begin
      checkValue("ramAddress", writeAddrLog[index], address);
      checkValue("ramOut", writeDataLog[index], data);
    end
  endtask

  // Read log checked in order against expectedReads
  task automatic checkReads();
    for (int i = 0; i < expectedReads.size(); i++)
      if (i < readLog.size())
        checkValue("ramAddress", readLog[i], expectedReads[i]);
  endtask

  task automatic waitForWrites(input int count);
    int cycles = 0;
    while (writeAddrLog.size() < count && cycles < timeoutCycles)
    begin
      @(posedge clk);
      cycles++;
    end
    assert (writeAddrLog.size() >= count)
    else
    begin
      $display("Timed out waiting for %0d RAM writes", count);
      errorCount++;
    end
  endtask

  task automatic waitForReads(input int count);
    int cycles = 0;
    while (readLog.size() < count && cycles < timeoutCycles)
    begin
      @(posedge clk);
      cycles++;
    end
    assert (readLog.size() >= count)
    else
    begin
      $display("Timed out waiting for %0d RAM reads", count);
      errorCount++;
    end
  endtask

  // Zero words decode as no-ops
  task automatic resetAndFetch();
    holdReset();
    releaseReset();
    checkValue("readReq", 32'(readReq), 0);
    checkValue("writeReq", 32'(writeReq), 0);
    @(negedge clk);
    checkValue("readReq", 32'(readReq), 1);
    checkValue("ramAddress", ramAddress, 0);
    expectedReads = '{0, 4, 8};
    waitForReads(3);
    checkReads();
    checkValue("write count", writeAddrLog.size(), 0);
  endtask

  task automatic arithmetic(input bit withRandomAck);
    logic [31:0] r2;
    logic [31:0] r3;
    logic [31:0] expected [5];
    holdReset();
    randomAck = withRandomAck;
    emitLong(isaPkg::opMovRC, 2, 0, arithConst[0]);
    emitLong(isaPkg::opMovRC, 3, 0, arithConst[1]);
    emitLong(isaPkg::opAddRC, 2, 0, arithConst[2]);
    emitLong(isaPkg::opMovdCR, 0, 2, 'h200);
    emitShort(isaPkg::opAddRR, 2, 3);
    emitLong(isaPkg::opMovdCR, 0, 2, 'h204);
    emitShort(isaPkg::opIncR, 3, 0);
    emitLong(isaPkg::opMovdCR, 0, 3, 'h208);
    emitShort(isaPkg::opDecR, 2, 0);
    emitLong(isaPkg::opMovdCR, 0, 2, 'h20C);
    emitLong(isaPkg::opMulAddRRC, 3, 2, arithConst[3]);
    emitLong(isaPkg::opMovdCR, 0, 3, 'h210);
    emitLong(isaPkg::opJmpC, 0, 0, codePtr);
    releaseReset();
    // Reference results wrap at 32 bits
    r2 = arithConst[0] + arithConst[2];
    expected[0] = r2;
    r3 = arithConst[1];
    r2 = r2 + r3;
    expected[1] = r2;
    r3 = r3 + 1;
    expected[2] = r3;
    r2 = r2 - 1;
    expected[3] = r2;
    r3 = r3 + r2 * arithConst[3];
    expected[4] = r3;
    waitForWrites(5);
    for (int i = 0; i < 5; i++)
      checkWrite(i, 32'h200 + 4 * i, expected[i]);
    // Slow RAM must not change any stored word
    if (!withRandomAck)
      firstArithData = writeDataLog;
    else
      for (int i = 0; i < firstArithData.size(); i++)
        if (i < writeDataLog.size())
          checkValue("ramOut", writeDataLog[i], firstArithData[i]);
  endtask

  task automatic memoryAddressing();
    holdReset();
    mem['h300 >> 2] = 32'hCAFE0001;
    mem['h308 >> 2] = 32'hCAFE0002;
    mem['h310 >> 2] = 32'hCAFE0003;
    emitLong(isaPkg::opMovRC, 4, 0, 'h308);
    emitLong(isaPkg::opMovRC, 5, 0, 'h10);
    emitLong(isaPkg::opMovRdC, 2, 0, 'h300);
    emitShort(isaPkg::opMovRdR, 3, 4);
    emitLong(isaPkg::opMovRdRo, 6, 5, 'h300);
    // Base in register A plus constant
    emitLong(isaPkg::opMovdRoR, 5, 2, 'h400);
    emitLong(isaPkg::opMovdRoR, 5, 3, 'h404);
    emitLong(isaPkg::opMovdRoR, 5, 6, 'h408);
    emitLong(isaPkg::opJmpC, 0, 0, codePtr);
    releaseReset();
    waitForWrites(3);
    checkWrite(0, 'h410, 32'hCAFE0001);
    checkWrite(1, 'h414, 32'hCAFE0002);
    checkWrite(2, 'h418, 32'hCAFE0003);
  endtask

  task automatic branchFlow();
    holdReset();
    emitLong(isaPkg::opMovRC, 2, 0, 5);
    emitLong(isaPkg::opMovRC, 3, 0, 5);
    emitShort(isaPkg::opCmpRR, 2, 3);
    emitLong(isaPkg::opJneC, 0, 0, 'h80);
    emitLong(isaPkg::opJeC, 0, 0, 'h40);
    codePtr = 'h40;
    emitLong(isaPkg::opCmpRC, 2, 0, 9);
    emitLong(isaPkg::opJeC, 0, 0, 'h80);
    emitLong(isaPkg::opJneC, 0, 0, 'h60);
    codePtr = 'h60;
    emitLong(isaPkg::opJmpC, 0, 0, 'h70);
    codePtr = 'h70;
    emitLong(isaPkg::opMovdCR, 0, 1, 'h500);
    emitLong(isaPkg::opCmpRC, 3, 0, 1);
    emitLong(isaPkg::opMovdCR, 0, 1, 'h504);
    emitLong(isaPkg::opJmpC, 0, 0, codePtr);
    releaseReset();
    // Not taken, taken, not taken, taken, then unconditional
    expectedReads = '{0, 4, 8, 12, 16, 20, 24, 28, 32, 'h40, 'h44, 'h48, 'h4C, 'h50, 'h54,
                      'h60, 'h64, 'h70, 'h74, 'h78, 'h7C, 'h80, 'h84};
    waitForWrites(2);
    waitForReads(expectedReads.size());
    checkReads();
    checkWrite(0, 'h500, lessBit);
    checkWrite(1, 'h504, greaterBit);
  endtask

  task automatic stackCalls();
    holdReset();
    emitLong(isaPkg::opMovRC, 2, 0, 'h11);
    emitLong(isaPkg::opMovRC, 3, 0, 'h22);
    emitShort(isaPkg::opPushR, 2, 0);
    emitShort(isaPkg::opPushR, 3, 0);
    emitShort(isaPkg::opPopR, 4, 0);
    emitLong(isaPkg::opMovdCR, 0, 4, 'h600);
    emitLong(isaPkg::opMovRC, 5, 0, 'h80);
    emitShort(isaPkg::opCallR, 5, 0);
    emitLong(isaPkg::opMovdCR, 0, 0, 'h604);
    emitLong(isaPkg::opJmpC, 0, 0, codePtr);
    codePtr = 'h80;
    emitShort(isaPkg::opRet, 0, 0);
    releaseReset();
    // Pop and return read just below the stack pointer
    expectedReads = '{0, 4, 8, 12, 16, 20, 24, 4, 28, 32, 36, 40, 44, 'h80, 4, 48, 52};
    waitForWrites(5);
    waitForReads(expectedReads.size());
    checkReads();
    checkWrite(0, 0, 'h11);
    checkWrite(1, 4, 'h22);
    checkWrite(2, 'h600, 'h22);
    checkWrite(3, 4, 44);
    checkWrite(4, 'h604, 4);
  endtask

  initial
  begin
    reset      = 1'b1;
    ramIn      = '0;
    readAck    = 1'b0;
    writeAck   = 1'b0;
    randomAck  = 1'b0;
    pendActive = 1'b0;
    for (int i = 0; i < 4; i++)
      arithConst[i] = $random(seed);
    resetAndFetch();
    arithmetic(1'b0);
    memoryAddressing();
    branchFlow();
    stackCalls();
    arithmetic(1'b1);
    $display("Checks: %0d, errors: %0d, assertion failures: %0d", checkCount, errorCount,
             i_cpuTop.i_cpuSva.assertFails);
    if (errorCount == 0 && i_cpuTop.i_cpuSva.assertFails == 0)
      $display("all tests passed");
    else
      $display("tests failed");
    $finish;
  end

endmodule

`default_nettype wire

/* dv/tbClockGen.sv */
`timescale 1ns/100ps
`default_nettype none

module tbClockGen #(
  parameter int halfPeriod = 20
) (
  output logic clk
);

  // 40 ns period starting low
  initial
  begin
    clk = 1'b0;
  end

  always #(halfPeriod) clk = ~clk;

endmodule

`default_nettype wire

/* rtl/corePkg.sv */
`default_nettype none

package corePkg;

  localparam int wordWidth = 32;

  // Byte step of the stack pointer per push or pop
  localparam int stackStep   = 4;
  localparam int shortLength = 4;
  localparam int longLength  = 8;

  // Registers with a fixed role
  localparam int stackPointerIndex = 0;
  localparam int flagIndex         = 1;

  // Sequencer modes
  localparam logic [2:0] modeFetchReq    = 3'd0;
  localparam logic [2:0] modeFetchWait   = 3'd1;
  localparam logic [2:0] modeOperandRead = 3'd2;
  localparam logic [2:0] modeConstWait   = 3'd3;
  localparam logic [2:0] modeDataReq     = 3'd4;
  localparam logic [2:0] modeDataWait    = 3'd5;
  localparam logic [2:0] modeRetire      = 3'd6;

  // Stack pointer adjust codes
  localparam logic [1:0] stackHold = 2'd0;
  localparam logic [1:0] stackUp   = 2'd1;
  localparam logic [1:0] stackDown = 2'd2;

endpackage

`default_nettype wire

/* rtl/cpuSequencer.sv */
`timescale 1ns/100ps
`default_nettype none

module cpuSequencer #(
  parameter int regCount = 16
) (
  input  logic                          clk,
  input  logic                          reset,
  input  logic [corePkg::wordWidth-1:0] ramIn,
  input  logic                          readAck,
  input  logic                          writeAck,
  input  logic [corePkg::wordWidth-1:0] operandA,
  input  logic [corePkg::wordWidth-1:0] operandB,
  input  logic [corePkg::wordWidth-1:0] stackPointer,
  input  isaPkg::flagWord               flags,
  output logic [corePkg::wordWidth-1:0] ramAddress,
  output logic [corePkg::wordWidth-1:0] ramOut,
  output logic                          readReq,
  output logic                          writeReq,
  output logic [7:0]                    opCode,
  output logic [corePkg::wordWidth-1:0] constWord,
  output logic [$clog2(regCount)-1:0]   readAddressA,
  output logic [$clog2(regCount)-1:0]   readAddressB,
  output logic                          captureOperands,
  output logic                          writeEnable,
  output logic [$clog2(regCount)-1:0]   writeAddress,
  output logic [corePkg::wordWidth-1:0] writeData,
  output logic [1:0]                    stackAdjust,
  output logic                          flagWrite,
  input  logic [corePkg::wordWidth-1:0] result
);

  localparam int addrBits = $clog2(regCount);

  logic [2:0]                    mode;
  logic [corePkg::wordWidth-1:0] ip;
  logic [corePkg::wordWidth-1:0] nextIp;
  logic [corePkg::wordWidth-1:0] loadData;
  logic [corePkg::wordWidth-1:0] dataAddress;
  logic [corePkg::wordWidth-1:0] storeData;
  logic                          isLoad;
  logic                          isStore;
  logic                          branchTaken;
  logic                          writesRegister;
  logic                          retire;

  assign isLoad  = isaPkg::isLoadOp(opCode);
  assign isStore = isaPkg::isStoreOp(opCode);
  assign retire  = (mode == corePkg::modeRetire);

  // Mode stepping and request pulses
  always_ff @(posedge clk or posedge reset)
  begin
    if (reset)
    begin
      mode     <= corePkg::modeFetchReq;
      ip       <= '0;
      opCode   <= '0;
      readReq  <= 1'b0;
      writeReq <= 1'b0;
    end
    else
    begin
      // Requests last a single cycle
      readReq  <= 1'b0;
      writeReq <= 1'b0;
      case (mode)
        corePkg::modeFetchReq:
        begin
          readReq <= 1'b1;
          mode    <= corePkg::modeFetchWait;
        end
        corePkg::modeFetchWait:
          if (readAck)
          begin
            opCode <= ramIn[isaPkg::opcodeLsb +: 8];
            mode   <= corePkg::modeOperandRead;
          end
        corePkg::modeOperandRead:
          if (isaPkg::isLongOp(opCode))
          begin
            // Constant sits right after the opcode word
            readReq <= 1'b1;
            mode    <= corePkg::modeConstWait;
          end
          else
            mode <= (isLoad || isStore) ? corePkg::modeDataReq : corePkg::modeRetire;
        corePkg::modeConstWait:
          if (readAck)
            mode <= (isLoad || isStore) ? corePkg::modeDataReq : corePkg::modeRetire;
        corePkg::modeDataReq:
        begin
          readReq  <= isLoad;
          writeReq <= isStore;
          mode     <= corePkg::modeDataWait;
        end
        corePkg::modeDataWait:
          if ((isLoad && readAck) || (isStore && writeAck))
            mode <= corePkg::modeRetire;
        corePkg::modeRetire:
        begin
          ip   <= nextIp;
          mode <= corePkg::modeFetchReq;
        end
        default:
          mode <= corePkg::modeFetchReq;
      endcase
    end
  end

  // Address, fields and captured words
  always_ff @(posedge clk)
  begin
    case (mode)
      corePkg::modeFetchReq:
        ramAddress <= ip;
      corePkg::modeFetchWait:
        if (readAck)
        begin
          readAddressA <= ramIn[isaPkg::regALsb +: addrBits];
          readAddressB <= ramIn[isaPkg::regBLsb +: addrBits];
        end
      corePkg::modeOperandRead:
        ramAddress <= ip + corePkg::shortLength;
      corePkg::modeConstWait:
        if (readAck)
          constWord <= ramIn;
      corePkg::modeDataReq:
      begin
        ramAddress <= dataAddress;
        ramOut     <= storeData;
      end
      corePkg::modeDataWait:
        if (readAck)
          loadData <= ramIn;
      default:
      begin
      end
    endcase
  end

  // Data address and store word per opcode
  always_comb
  begin
    storeData = operandB;
    case (opCode)
      isaPkg::opMovdCR:  dataAddress = constWord;
      isaPkg::opMovRdC:  dataAddress = constWord;
      isaPkg::opMovRdRo: dataAddress = constWord + operandB;
      isaPkg::opMovdRoR: dataAddress = constWord + operandA;
      isaPkg::opMovRdR:  dataAddress = operandB;
      isaPkg::opPopR:    dataAddress = stackPointer - corePkg::stackStep;
      isaPkg::opRet:     dataAddress = stackPointer - corePkg::stackStep;
      default:           dataAddress = stackPointer;
    endcase
    if (opCode == isaPkg::opPushR)
      storeData = operandA;
    // Return address is the call itself
    if (opCode == isaPkg::opCallR)
      storeData = ip;
  end

  // Flag test for conditional jumps
  assign branchTaken = (opCode == isaPkg::opJmpC)
                    || (opCode == isaPkg::opJeC && flags.bits.equal)
                    || (opCode == isaPkg::opJneC && !flags.bits.equal);

  always_comb
  begin
    if (branchTaken)
      nextIp = constWord;
    else if (opCode == isaPkg::opCallR)
      nextIp = operandA;
    else if (opCode == isaPkg::opRet)
      nextIp = loadData + corePkg::shortLength;
    else if (isaPkg::isLongOp(opCode))
      nextIp = ip + corePkg::longLength;
    else
      nextIp = ip + corePkg::shortLength;
  end

  assign writesRegister = opCode inside {isaPkg::opMovRC, isaPkg::opMovRR, isaPkg::opMovRdC,
                                         isaPkg::opMovRdR, isaPkg::opMovRdRo, isaPkg::opPopR,
                                         isaPkg::opAddRC, isaPkg::opAddRR, isaPkg::opIncR,
                                         isaPkg::opDecR, isaPkg::opMulAddRRC};

  // Retire strobes
  assign captureOperands = (mode == corePkg::modeOperandRead);
  assign writeEnable     = retire && writesRegister;
  assign writeAddress    = readAddressA;
  assign flagWrite       = retire && (opCode == isaPkg::opCmpRR || opCode == isaPkg::opCmpRC);

  always_comb
  begin
    if (opCode == isaPkg::opMovRC)
      writeData = constWord;
    else if (isLoad)
      writeData = loadData;
    else if (opCode == isaPkg::opMovRR)
      writeData = operandB;
    else
      writeData = result;
  end

  always_comb
  begin
    stackAdjust = corePkg::stackHold;
    if (retire && (opCode == isaPkg::opPushR || opCode == isaPkg::opCallR))
      stackAdjust = corePkg::stackUp;
    else if (retire && (opCode == isaPkg::opPopR || opCode == isaPkg::opRet))
      stackAdjust = corePkg::stackDown;
  end

endmodule

`default_nettype wire

/* rtl/cpuTop.sv */
`timescale 1ns/100ps
`default_nettype none

module cpuTop #(
  parameter int regCount = 16
) (
  input  logic                          clk,
  input  logic                          reset,
  input  logic [corePkg::wordWidth-1:0] ramIn,
  input  logic                          readAck,
  input  logic                          writeAck,
  output logic [corePkg::wordWidth-1:0] ramAddress,
  output logic [corePkg::wordWidth-1:0] ramOut,
  output logic                          readReq,
  output logic                          writeReq
);

  logic [corePkg::wordWidth-1:0] operandA;
  logic [corePkg::wordWidth-1:0] operandB;
  logic [corePkg::wordWidth-1:0] stackPointer;
  logic [corePkg::wordWidth-1:0] constWord;
  logic [corePkg::wordWidth-1:0] result;
  logic [corePkg::wordWidth-1:0] writeData;
  logic [$clog2(regCount)-1:0]   readAddressA;
  logic [$clog2(regCount)-1:0]   readAddressB;
  logic [$clog2(regCount)-1:0]   writeAddress;
  logic [7:0]                    opCode;
  logic [1:0]                    stackAdjust;
  logic                          captureOperands;
  logic                          writeEnable;
  logic                          flagWrite;
  isaPkg::flagWord               flags;
  isaPkg::flagWord               flagValue;

  // Control and RAM port
  cpuSequencer #(
    .regCount(regCount)
  ) i_cpuSequencer (
    .clk            (clk),
    .reset          (reset),
    .ramIn          (ramIn),
    .readAck        (readAck),
    .writeAck       (writeAck),
    .operandA       (operandA),
    .operandB       (operandB),
    .stackPointer   (stackPointer),
    .flags          (flags),
    .ramAddress     (ramAddress),
    .ramOut         (ramOut),
    .readReq        (readReq),
    .writeReq       (writeReq),
    .opCode         (opCode),
    .constWord      (constWord),
    .readAddressA   (readAddressA),
    .readAddressB   (readAddressB),
    .captureOperands(captureOperands),
    .writeEnable    (writeEnable),
    .writeAddress   (writeAddress),
    .writeData      (writeData),
    .stackAdjust    (stackAdjust),
    .flagWrite      (flagWrite),
    .result         (result)
  );

  registerFile #(
    .regCount(regCount)
  ) i_registerFile (
    .clk            (clk),
    .reset          (reset),
    .readAddressA   (readAddressA),
    .readAddressB   (readAddressB),
    .captureOperands(captureOperands),
    .writeEnable    (writeEnable),
    .writeAddress   (writeAddress),
    .writeData      (writeData),
    .stackAdjust    (stackAdjust),
    .flagWrite      (flagWrite),
    .flagValue      (flagValue),
    .operandA       (operandA),
    .operandB       (operandB),
    .stackPointer   (stackPointer),
    .flags          (flags)
  );

  // Combinational unit sampled at retire
  integerExecute i_integerExecute (
    .opCode   (opCode),
    .operandA (operandA),
    .operandB (operandB),
    .constWord(constWord),
    .result   (result),
    .flagValue(flagValue)
  );

endmodule

`default_nettype wire

/* rtl/integerExecute.sv */
`timescale 1ns/100ps
`default_nettype none

module integerExecute (
  input  logic [7:0]                    opCode,
  input  logic [corePkg::wordWidth-1:0] operandA,
  input  logic [corePkg::wordWidth-1:0] operandB,
  input  logic [corePkg::wordWidth-1:0] constWord,
  output logic [corePkg::wordWidth-1:0] result,
  output isaPkg::flagWord               flagValue
);

  logic [corePkg::wordWidth-1:0] compareWith;

  // Arithmetic wraps at 32 bits
  always_comb
  begin
    case (opCode)
      isaPkg::opAddRC:
        result = operandA + constWord;
      isaPkg::opAddRR:
        result = operandA + operandB;
      isaPkg::opIncR:
        result = operandA + 32'd1;
      isaPkg::opDecR:
        result = operandA - 32'd1;
      isaPkg::opMulAddRRC:
        result = operandA + operandB * constWord;
      default:
        result = '0;
    endcase
  end

  // Second compare operand from register or constant
  assign compareWith = (opCode == isaPkg::opCmpRC) ? constWord : operandB;

  // Unsigned compare bits
  always_comb
  begin
    flagValue              = '0;
    flagValue.bits.equal   = (operandA == compareWith);
    flagValue.bits.less    = (operandA < compareWith);
    flagValue.bits.greater = (operandA > compareWith);
  end

endmodule

`default_nettype wire

/* rtl/isaPkg.sv */
`default_nettype none

package isaPkg;

  // Opcode byte values
  localparam logic [7:0] opMovRC     = 8'h01;
  localparam logic [7:0] opMovRR     = 8'h02;
  localparam logic [7:0] opMovRdC    = 8'h03;
  localparam logic [7:0] opMovRdR    = 8'h04;
  localparam logic [7:0] opMovRdRo   = 8'h05;
  localparam logic [7:0] opMovdCR    = 8'h06;
  localparam logic [7:0] opMovdRoR   = 8'h07;
  localparam logic [7:0] opPushR     = 8'h10;
  localparam logic [7:0] opPopR      = 8'h11;
  localparam logic [7:0] opCallR     = 8'h12;
  localparam logic [7:0] opRet       = 8'h13;
  localparam logic [7:0] opCmpRR     = 8'h20;
  localparam logic [7:0] opCmpRC     = 8'h21;
  localparam logic [7:0] opJmpC      = 8'h30;
  localparam logic [7:0] opJeC       = 8'h31;
  localparam logic [7:0] opJneC      = 8'h32;
  localparam logic [7:0] opAddRC     = 8'h40;
  localparam logic [7:0] opAddRR     = 8'h41;
  localparam logic [7:0] opIncR      = 8'h42;
  localparam logic [7:0] opDecR      = 8'h43;
  localparam logic [7:0] opMulAddRRC = 8'h44;

  // Byte lanes of the instruction word
  localparam int opcodeLsb = 0;
  localparam int regALsb   = 8;
  localparam int regBLsb   = 16;

  // Register 1 seen as a word or as compare bits
  typedef union packed {
    logic [31:0] word;
    struct packed {
      logic [28:0] unused;
      logic        greater;
      logic        less;
      logic        equal;
    } bits;
  } flagWord;

  // Followed by a constant word
  function automatic logic isLongOp(input logic [7:0] op);
    return op inside {opMovRC, opMovRdC, opMovRdRo, opMovdCR, opMovdRoR, opCmpRC,
                      opJmpC, opJeC, opJneC, opAddRC, opMulAddRRC};
  endfunction

  function automatic logic isLoadOp(input logic [7:0] op);
    return op inside {opMovRdC, opMovRdR, opMovRdRo, opPopR, opRet};
  endfunction

  function automatic logic isStoreOp(input logic [7:0] op);
    return op inside {opMovdCR, opMovdRoR, opPushR, opCallR};
  endfunction

endpackage

`default_nettype wire

/* rtl/registerFile.sv */
`timescale 1ns/100ps
`default_nettype none

module registerFile #(
  parameter int regCount = 16
) (
  input  logic                          clk,
  input  logic                          reset,
  input  logic [$clog2(regCount)-1:0]   readAddressA,
  input  logic [$clog2(regCount)-1:0]   readAddressB,
  input  logic                          captureOperands,
  input  logic                          writeEnable,
  input  logic [$clog2(regCount)-1:0]   writeAddress,
  input  logic [corePkg::wordWidth-1:0] writeData,
  input  logic [1:0]                    stackAdjust,
  input  logic                          flagWrite,
  input  isaPkg::flagWord               flagValue,
  output logic [corePkg::wordWidth-1:0] operandA,
  output logic [corePkg::wordWidth-1:0] operandB,
  output logic [corePkg::wordWidth-1:0] stackPointer,
  output isaPkg::flagWord               flags
);

  logic [corePkg::wordWidth-1:0] regs [regCount];

  always_ff @(posedge clk or posedge reset)
  begin
    if (reset)
    begin
      for (int i = 0; i < regCount; i++)
        regs[i] <= '0;
    end
    else
    begin
      // Stack step first
      case (stackAdjust)
        corePkg::stackUp:
          regs[corePkg::stackPointerIndex] <= stackPointer + corePkg::stackStep;
        corePkg::stackDown:
          regs[corePkg::stackPointerIndex] <= stackPointer - corePkg::stackStep;
        default:
        begin
        end
      endcase
      if (flagWrite)
        regs[corePkg::flagIndex] <= flagValue.word;
      // Data write wins, so a pop into the stack pointer keeps the loaded word
      if (writeEnable)
        regs[writeAddress] <= writeData;
    end
  end

  // Operands held through the rest of the instruction
  always_ff @(posedge clk)
  begin
    if (captureOperands)
    begin
      operandA <= regs[readAddressA];
      operandB <= regs[readAddressB];
    end
  end

  assign stackPointer = regs[corePkg::stackPointerIndex];
  assign flags        = regs[corePkg::flagIndex];

endmodule

`default_nettype wire

/* verilog.f */
rtl/isaPkg.sv
rtl/corePkg.sv
rtl/integerExecute.sv
rtl/registerFile.sv
rtl/cpuSequencer.sv
rtl/cpuTop.sv
dv/tbClockGen.sv
dv/cpuSva.sv
dv/cpuTb.sv
